//--- flist.f
+incdir+hdl
hdl/led_matrix_pkg.sv
hdl/timeout.sv
hdl/brightness_timeout.sv
hdl/matrix_scan.sv
hdl/framebuffer.sv
hdl/pixel_plane_select.sv
hdl/led_matrix_top.sv
verif/led_matrix_tb.sv

//--- Bender.yml
package:
  name: led_matrix

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/led_matrix_pkg.sv
      - hdl/timeout.sv
      - hdl/brightness_timeout.sv
      - hdl/matrix_scan.sv
      - hdl/framebuffer.sv
      - hdl/pixel_plane_select.sv
      - hdl/led_matrix_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/led_matrix_tb.sv

//--- verif/led_matrix_tb.sv
// testbench for the led matrix driver that writes pixels, models the panel
// and checks every latched line with its row, its plane and its lit time
`default_nettype none

`include "led_matrix_settings.svh"

module led_matrix_tb
    import led_matrix_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned COLS = `PIXEL_WIDTH;
    localparam int unsigned HALF_ROWS = `PANEL_ROWS;
    localparam int unsigned PLANES = `BRIGHTNESS_LEVELS;
    localparam int unsigned FRAME_LATCHES = `PANEL_ROWS * `BRIGHTNESS_LEVELS;
    // upper bound on clock cycles from one row latch to the next
    localparam int unsigned LATCH_CYCLES = 400;

    logic               clk_in;
    logic               reset;
    logic               wr_strobe;
    col_addr_t          wr_column;
    row_addr_t          wr_row;
    rgb_pixel_t         wr_pixel;
    panel_rgb_t         panel_rgb;
    row_subpanel_addr_t row_address_active;
    logic               clk_pixel;
    logic               row_latch;
    logic               output_enable;

    // pixels as the host wrote them
    rgb_pixel_t  frame [2 * HALF_ROWS][COLS];
    // panel model where column c ends up in entry c
    logic [5:0]  shift_line [COLS];
    int unsigned pixel_pulses;
    // expected scan position and measurements
    int unsigned latch_count;
    int unsigned last_pulses;
    int unsigned lit_cycles;
    int unsigned exp_row;
    int unsigned exp_plane;
    int unsigned prev_plane;
    int unsigned last_row_seen;
    logic        seen_latch;
    logic        armed;
    logic        wrap_seen;
    logic        timed_out;
    int unsigned errors;
    int unsigned checks;
    logic [31:0] lfsr;

    always #10 clk_in = ~clk_in;

    led_matrix_top dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .wr_strobe         (wr_strobe),
        .wr_column         (wr_column),
        .wr_row            (wr_row),
        .wr_pixel          (wr_pixel),
        .panel_rgb         (panel_rgb),
        .row_address_active(row_address_active),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable)
    );

    // six colour bits for one column of a line in upper then lower rgb order
    function automatic logic [5:0] expected_bits(int unsigned row, int unsigned col,
                                                 int unsigned plane);
        logic [11:0] upper;
        logic [11:0] lower;
        upper = frame[row][col];
        lower = frame[row + HALF_ROWS][col];
        return {upper[8 + plane], upper[4 + plane], upper[plane],
                lower[8 + plane], lower[4 + plane], lower[plane]};
    endfunction

    // galois lfsr that shifts right and folds the taps back in
    function automatic logic [31:0] lfsr_next(logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h80200003;
        end
        return next;
    endfunction

    // one lfsr step per pixel bit
    task automatic random_pixel(output rgb_pixel_t pixel);
        logic [11:0] bits;
        bits = '0;
        for (int i = 0; i < 12; i++) begin
            bits = {bits[10:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        pixel = bits;
    endtask

    task automatic report_mismatch(string name, int unsigned expected, int unsigned actual);
        errors++;
        $display("MISMATCH at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    // called 2 ns after a rising edge and returns at the same point one cycle on
    task automatic write_pixel(int unsigned row, int unsigned col, rgb_pixel_t pixel);
        wr_strobe = 1'b1;
        wr_row = row_addr_t'(row);
        wr_column = col_addr_t'(col);
        wr_pixel = pixel;
        frame[row][col] = pixel;
        @(posedge clk_in);
        #2;
        wr_strobe = 1'b0;
    endtask

    task automatic fill_random_frame();
        rgb_pixel_t pixel;
        for (int r = 0; r < 2 * HALF_ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                random_pixel(pixel);
                write_pixel(r, c, pixel);
            end
        end
    endtask

    // upper and lower halves get opposite solid rows
    task automatic fill_solid_frame();
        for (int r = 0; r < 2 * HALF_ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                write_pixel(r, c, ((r % 2) == (r / HALF_ROWS)) ? 12'hfff : 12'h000);
            end
        end
    endtask

    task automatic wait_latches(int unsigned count);
        int unsigned target;
        int unsigned cycles;
        target = latch_count + count;
        cycles = 0;
        while (latch_count < target && !timed_out) begin
            @(posedge clk_in);
            #2;
            cycles++;
            if (cycles > count * LATCH_CYCLES) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: %0d row latches did not arrive in %0d cycles", count, cycles);
            end
        end
    endtask

    task automatic report_test(int unsigned number, string name, int unsigned start_errors);
        $display("test %0d %s: %0d errors", number, name, errors - start_errors);
    endtask

    // shift in on the rising pixel clock
    always @(posedge clk_pixel) begin
        for (int i = COLS - 1; i > 0; i--) begin
            shift_line[i] <= shift_line[i - 1];
        end
        shift_line[0] <= panel_rgb;
        pixel_pulses <= pixel_pulses + 1;
    end

    // row latch is high across one rising edge where the line is checked
    always @(posedge clk_in) begin : compare_lines
        logic [5:0] want;
        if (reset) begin
            exp_row = 0;
            exp_plane = PLANES - 1;
            last_pulses = pixel_pulses;
            lit_cycles = 0;
            seen_latch = 1'b0;
        end else begin
            if (output_enable) begin
                lit_cycles++;
            end
            if (row_latch) begin
                checks++;
                if (pixel_pulses - last_pulses != COLS) begin
                    report_mismatch("clk_pixel pulses", COLS, pixel_pulses - last_pulses);
                end
                last_pulses = pixel_pulses;
                // lit time of the plane latched before this one
                checks++;
                if (seen_latch) begin
                    if (lit_cycles != (`BRIGHTNESS_BASE_TIMEOUT << prev_plane)) begin
                        report_mismatch("output_enable cycles",
                            `BRIGHTNESS_BASE_TIMEOUT << prev_plane, lit_cycles);
                    end
                end else if (lit_cycles != 0) begin
                    report_mismatch("output_enable cycles before first latch", 0, lit_cycles);
                end
                lit_cycles = 0;
                checks++;
                if (row_address_active !== 4'(exp_row)) begin
                    report_mismatch("row_address_active", exp_row, row_address_active);
                end
                if (last_row_seen == HALF_ROWS - 1 && row_address_active == 0) begin
                    wrap_seen = 1'b1;
                end
                last_row_seen = row_address_active;
                if (armed) begin
                    for (int c = 0; c < COLS; c++) begin
                        want = expected_bits(exp_row, c, exp_plane);
                        checks++;
                        if (shift_line[c] !== want) begin
                            report_mismatch($sformatf("panel_rgb row %0d column %0d plane %0d",
                                exp_row, c, exp_plane), want, shift_line[c]);
                        end
                    end
                end
                // msb plane first, then the next row
                prev_plane = exp_plane;
                seen_latch = 1'b1;
                if (exp_plane == 0) begin
                    exp_plane = PLANES - 1;
                    exp_row = (exp_row + 1) % HALF_ROWS;
                end else begin
                    exp_plane--;
                end
                latch_count++;
            end
        end
    end

    initial begin
        int unsigned start_errors;
        int unsigned cycles;
        clk_in = 1'b0;
        reset = 1'b1;
        wr_strobe = 1'b0;
        wr_column = '0;
        wr_row = '0;
        wr_pixel = '0;
        lfsr = 32'he71d1bcf;
        pixel_pulses = 0;
        latch_count = 0;
        last_row_seen = 0;
        armed = 1'b0;
        wrap_seen = 1'b0;
        timed_out = 1'b0;
        errors = 0;
        checks = 0;
        repeat (10) @(posedge clk_in);
        #2;
        reset = 1'b0;

        // leds dark and no latch until the first line is in
        start_errors = errors;
        cycles = 0;
        while (latch_count == 0 && !timed_out) begin
            checks++;
            if (output_enable !== 1'b0) begin
                report_mismatch("output_enable", 0, output_enable);
            end
            if (row_latch !== 1'b0) begin
                report_mismatch("row_latch", 0, row_latch);
            end
            @(posedge clk_in);
            #2;
            cycles++;
            if (cycles > LATCH_CYCLES) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: no row latch within %0d cycles of reset", cycles);
            end
        end
        report_test(1, "reset state and first line", start_errors);

        // skip the line that was shifting while the frame was written
        start_errors = errors;
        fill_random_frame();
        wait_latches(1);
        armed = 1'b1;
        wait_latches(FRAME_LATCHES);
        report_test(2, "random frame", start_errors);

        start_errors = errors;
        wrap_seen = 1'b0;
        wait_latches(FRAME_LATCHES + PLANES);
        if (!wrap_seen) begin
            errors++;
            $display("row_address_active never went from 15 back to 0 over a frame");
        end
        report_test(3, "plane and row order", start_errors);

        start_errors = errors;
        wait_latches(FRAME_LATCHES);
        report_test(4, "lit time per plane", start_errors);

        start_errors = errors;
        armed = 1'b0;
        fill_random_frame();
        wait_latches(1);
        armed = 1'b1;
        wait_latches(FRAME_LATCHES);
        armed = 1'b0;
        fill_solid_frame();
        wait_latches(1);
        armed = 1'b1;
        wait_latches(FRAME_LATCHES);
        report_test(5, "overwritten and solid frames", start_errors);

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/led_matrix_top.sv
// top level of the led matrix driver
// host pixel writes in, hub75 colour, row, clock, latch and enable pins out
`default_nettype none

module led_matrix_top
    import led_matrix_pkg::*;
(
    input  logic               clk_in,
    input  logic               reset,
    // host write port, one pixel per strobe
    input  logic               wr_strobe,
    input  col_addr_t          wr_column,
    input  row_addr_t          wr_row,
    input  rgb_pixel_t         wr_pixel,
    // panel pins
    output panel_rgb_t         panel_rgb,
    output row_subpanel_addr_t row_address_active,
    output logic               clk_pixel,
    output logic               row_latch,
    output logic               output_enable
);

    col_addr_t          column_address;
    row_subpanel_addr_t row_address;
    brightness_level_t  brightness_mask;
    rgb_pixel_t         pixel_upper;
    rgb_pixel_t         pixel_lower;

    // load clock stays internal, the read pipeline is timed off the column count
    matrix_scan matrix_scan_inst (
        .reset             (reset),
        .clk_in            (clk_in),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .clk_pixel_load    (),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .brightness_mask   (brightness_mask)
    );

    framebuffer framebuffer_inst (
        .clk_in     (clk_in),
        .wr_strobe  (wr_strobe),
        .wr_column  (wr_column),
        .wr_row     (wr_row),
        .wr_pixel   (wr_pixel),
        .rd_column  (column_address),
        .rd_row     (row_address),
        .pixel_upper(pixel_upper),
        .pixel_lower(pixel_lower)
    );

    pixel_plane_select pixel_plane_select_inst (
        .clk_in         (clk_in),
        .reset          (reset),
        .pixel_upper    (pixel_upper),
        .pixel_lower    (pixel_lower),
        .brightness_mask(brightness_mask),
        .panel_rgb      (panel_rgb)
    );

endmodule

`default_nettype wire

//--- hdl/pixel_plane_select.sv
// picks the active bit plane out of both read pixels
// registers the six colour pins one cycle ahead of the pixel clock edge
`default_nettype none

module pixel_plane_select
    import led_matrix_pkg::*;
(
    input  logic              clk_in,
    input  logic              reset,
    input  rgb_pixel_t        pixel_upper,
    input  rgb_pixel_t        pixel_lower,
    input  brightness_level_t brightness_mask,
    output panel_rgb_t        panel_rgb
);

    panel_rgb_t plane_bits;

    // one bit per channel, set when the masked plane bit is set
    always_comb begin
        plane_bits.upper_red   = |(pixel_upper.red & brightness_mask);
        plane_bits.upper_green = |(pixel_upper.green & brightness_mask);
        plane_bits.upper_blue  = |(pixel_upper.blue & brightness_mask);
        plane_bits.lower_red   = |(pixel_lower.red & brightness_mask);
        plane_bits.lower_green = |(pixel_lower.green & brightness_mask);
        plane_bits.lower_blue  = |(pixel_lower.blue & brightness_mask);
    end

    // held stable across the next rising pixel clock
    always_ff @(posedge clk_in) begin
        if (reset) begin
            panel_rgb <= '0;
        end else begin
            panel_rgb <= plane_bits;
        end
    end

endmodule

`default_nettype wire

//--- hdl/framebuffer.sv
// pixel memory for the whole panel, one bank per half
// the host writes single pixels, the scan reads both halves at one address
`default_nettype none

`include "led_matrix_settings.svh"

module framebuffer
    import led_matrix_pkg::*;
(
    input  logic               clk_in,
    input  logic               wr_strobe,
    input  col_addr_t          wr_column,
    input  row_addr_t          wr_row,
    input  rgb_pixel_t         wr_pixel,
    input  col_addr_t          rd_column,
    input  row_subpanel_addr_t rd_row,
    output rgb_pixel_t         pixel_upper,
    output rgb_pixel_t         pixel_lower
);

    localparam int unsigned BANK_DEPTH = `PANEL_ROWS * `PIXEL_WIDTH;
    localparam int unsigned BANK_ADDR_WIDTH = $bits(row_subpanel_addr_t) + $bits(col_addr_t);

    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

    rgb_pixel_t bank_upper [BANK_DEPTH];
    rgb_pixel_t bank_lower [BANK_DEPTH];
    bank_addr_t wr_addr;
    bank_addr_t rd_addr;
    logic       wr_lower;

    // row msb picks the half, the rest addresses within it
    assign wr_lower = wr_row[$bits(row_addr_t)-1];
    assign wr_addr = {wr_row[$bits(row_subpanel_addr_t)-1:0], wr_column};
    assign rd_addr = {rd_row, rd_column};

    // upper half, rows 0 to 15
    always_ff @(posedge clk_in) begin
        if (wr_strobe && !wr_lower) begin
            bank_upper[wr_addr] <= wr_pixel;
        end
        pixel_upper <= bank_upper[rd_addr];
    end

    // lower half, rows 16 to 31
    always_ff @(posedge clk_in) begin
        if (wr_strobe && wr_lower) begin
            bank_lower[wr_addr] <= wr_pixel;
        end
        pixel_lower <= bank_lower[rd_addr];
    end

endmodule

`default_nettype wire

//--- hdl/matrix_scan.sv
// scan sequencer for the panel that steps through rows and bit planes
// makes the column count, the gated load and pixel clocks, the row latch
// and the plane mask, and starts each line once the lit time allows it
`default_nettype none

`include "led_matrix_settings.svh"

module matrix_scan
    import led_matrix_pkg::*;
(
    input  logic               reset,
    input  logic               clk_in,
    // column being shifted out now
    output col_addr_t          column_address,
    // row being shifted out now
    output row_subpanel_addr_t row_address,
    // row whose leds are lit
    output row_subpanel_addr_t row_address_active,
    output logic               clk_pixel_load,
    output logic               clk_pixel,
    output logic               row_latch,
    output logic               output_enable,
    // plane picked out of each channel for the line being shifted
    output brightness_level_t  brightness_mask
);

    localparam int unsigned LOAD_WIDTH = width_for_count(`PIXEL_WIDTH);
    localparam int unsigned COLUMN_WIDTH = $bits(col_addr_t);
    localparam brightness_level_t MASK_MSB =
        brightness_level_t'(1 << (`BRIGHTNESS_LEVELS - 1));

    // advance condition history with the oldest in bit 1
    logic [1:0]        state;
    logic              state_advance;
    logic              column_start;
    // column count leads the load clock by the two read registers
    logic [1:0]        load_delay;
    logic              clk_pixel_load_en;
    logic              clk_pixel_en;
    // load enable seen on the last two falling edges
    logic [1:0]        row_latch_state;
    logic              exceeded_overlap_time;
    brightness_level_t brightness_mask_active;

    // gated clocks pulse during the high phase of clk_in
    assign clk_pixel_load = clk_in & clk_pixel_load_en;
    assign clk_pixel = clk_in & clk_pixel_en;

    // latch once the load enable has dropped
    assign row_latch = (row_latch_state == 2'b10);

    // shift the next line while the previous one is lit,
    // but not before the overlap time has passed
    assign state_advance = !output_enable || exceeded_overlap_time;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state      <= 2'b00;
            load_delay <= 2'b00;
        end else begin
            state      <= {state[0], state_advance};
            load_delay <= {load_delay[0], column_start};
        end
    end

    // rising edge of the advance condition starts one line
    assign column_start = (state == 2'b01);

    // column counts 63 down to 0 and parks at 0
    timeout #(
        .COUNTER_WIDTH(COLUMN_WIDTH)
    ) timeout_column_address (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (column_start),
        .value  (COLUMN_WIDTH'(`PIXEL_WIDTH - 1)),
        .counter(column_address),
        .running()
    );

    // exactly one load clock per column
    timeout #(
        .COUNTER_WIDTH(LOAD_WIDTH)
    ) timeout_clk_pixel_load_en (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (load_delay[1]),
        .value  (LOAD_WIDTH'(`PIXEL_WIDTH)),
        .counter(),
        .running(clk_pixel_load_en)
    );

    // pixel clock trails the load clock by one cycle
    always_ff @(negedge clk_in) begin
        if (reset) begin
            clk_pixel_en           <= 1'b0;
            row_latch_state        <= 2'b00;
            brightness_mask        <= MASK_MSB;
            brightness_mask_active <= '0;
            row_address            <= '0;
            row_address_active     <= '0;
        end else begin
            clk_pixel_en    <= clk_pixel_load_en;
            row_latch_state <= {row_latch_state[0], clk_pixel_load_en};
            // row latch rises on this edge and the latched line goes live
            if (row_latch_state[0] && !clk_pixel_load_en) begin
                brightness_mask_active <= brightness_mask;
                row_address_active     <= row_address;
            end
            // end of the latch pulse steps to the next plane
            if (row_latch) begin
                if (brightness_mask[0]) begin
                    // after the lsb plane go back to msb on the next row
                    brightness_mask <= MASK_MSB;
                    row_address     <= row_address + 1'b1;
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

    brightness_timeout brightness_timeout_inst (
        .clk_in                (clk_in),
        .reset                 (reset),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask_active),
        .output_enable         (output_enable),
        .exceeded_overlap_time (exceeded_overlap_time)
    );

endmodule

`default_nettype wire

//--- hdl/brightness_timeout.sv
// output enable timer for binary-coded modulation
// a row latch loads the lit time of the latched plane, and the overlap flag
// tells the scan when the next line may start shifting
`default_nettype none

`include "led_matrix_settings.svh"

module brightness_timeout
    import led_matrix_pkg::*;
(
    input  logic              clk_in,
    input  logic              reset,
    input  logic              row_latch,
    input  brightness_level_t brightness_mask_active,
    output logic              output_enable,
    output logic              exceeded_overlap_time
);

    // the msb plane gets the longest lit time
    localparam int unsigned LIT_MAX =
        `BRIGHTNESS_BASE_TIMEOUT << (`BRIGHTNESS_LEVELS - 1);
    localparam int unsigned LIT_WIDTH = width_for_count(LIT_MAX);
    localparam int unsigned OVERLAP_WIDTH = width_for_count(`BRIGHTNESS_STATE_TIMEOUT_OVERLAP);
    localparam logic [LIT_WIDTH-1:0] LIT_BASE = LIT_WIDTH'(`BRIGHTNESS_BASE_TIMEOUT);
    localparam logic [OVERLAP_WIDTH-1:0] OVERLAP =
        OVERLAP_WIDTH'(`BRIGHTNESS_STATE_TIMEOUT_OVERLAP);
    // a line takes longer than this to shift and latch
    localparam logic [LIT_WIDTH-1:0] LINE_GUARD = LIT_WIDTH'(`PIXEL_WIDTH);

    logic [LIT_WIDTH-1:0]     lit_time;
    logic [LIT_WIDTH-1:0]     lit_count;
    logic [OVERLAP_WIDTH-1:0] overlap_count;

    // base time scaled by the binary weight of the plane
    always_comb begin
        lit_time = LIT_BASE << plane_index(brightness_mask_active);
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            lit_count     <= '0;
            overlap_count <= '0;
        end else if (row_latch) begin
            lit_count     <= lit_time;
            overlap_count <= OVERLAP;
        end else begin
            if (lit_count != '0) begin
                lit_count <= lit_count - 1'b1;
            end
            if (overlap_count != '0) begin
                overlap_count <= overlap_count - 1'b1;
            end
        end
    end

    // leds on while the lit count runs
    assign output_enable = (lit_count != '0);

    // overlap time is over, and a line started now latches no earlier than
    // the end of this lit period, so no plane gets cut short
    assign exceeded_overlap_time = (overlap_count == '0) && (lit_count <= LINE_GUARD);

endmodule

`default_nettype wire

//--- hdl/timeout.sv
// loadable down-counter, a start pulse loads value and the count runs to zero
// running stays high for exactly value cycles after the load
`default_nettype none

module timeout #(
    parameter int unsigned COUNTER_WIDTH = 8
) (
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    output logic                     running
);

    // start wins over the count, so a restart mid-count reloads cleanly
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    // zero is the idle state, the counter parks there
    assign running = (counter != '0);

endmodule

`default_nettype wire

//--- hdl/led_matrix_pkg.sv
// shared types and width helpers for the led matrix driver
// modules pull these in with a wildcard import in their header
`default_nettype none

`include "led_matrix_settings.svh"

package led_matrix_pkg;

    // addresses into the panel
    typedef logic [$clog2(`PIXEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(`PANEL_ROWS)-1:0] row_subpanel_addr_t;
    typedef logic [$clog2(2 * `PANEL_ROWS)-1:0] row_addr_t;

    // one-hot bit plane select, msb plane first
    typedef logic [`BRIGHTNESS_LEVELS-1:0] brightness_level_t;
    typedef logic [`BRIGHTNESS_LEVELS-1:0] channel_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb_pixel_t;

    // colour pins as the panel connector orders them
    typedef struct packed {
        logic upper_red;
        logic upper_green;
        logic upper_blue;
        logic lower_red;
        logic lower_green;
        logic lower_blue;
    } panel_rgb_t;

    // bits needed to hold every value from 0 up to count
    function automatic int unsigned width_for_count(int unsigned count);
        return $clog2(count + 1);
    endfunction

    // position of the set bit in a one-hot plane mask
    function automatic int unsigned plane_index(brightness_level_t mask);
        int unsigned index;
        index = 0;
        for (int unsigned i = 0; i < $bits(brightness_level_t); i++) begin
            if (mask[i]) begin
                index = i;
            end
        end
        return index;
    endfunction

endpackage

`default_nettype wire

//--- hdl/led_matrix_settings.svh
// panel geometry and brightness timing for the led matrix driver
// included by the package and by every module that needs a size or a time
`ifndef LED_MATRIX_SETTINGS_SVH
`define LED_MATRIX_SETTINGS_SVH

// columns per line, shifted out once per bit plane
`define PIXEL_WIDTH 64

// rows in one half of the panel, both halves share the row address
`define PANEL_ROWS 16

// bit planes per colour channel, one per bit of the channel value
`define BRIGHTNESS_LEVELS 4

// lit time of the lsb plane in clock cycles
`define BRIGHTNESS_BASE_TIMEOUT 16

// lit cycles that must pass before the next line may start shifting
`define BRIGHTNESS_STATE_TIMEOUT_OVERLAP 8

`endif
